// ==== flist.f ====
vgaPkg.sv
mousePkg.sv
ps2Receiver.sv
mousePacket.sv
cursorTracker.sv
vgaTiming.sv
bitmapArbiter.sv
pixelRenderer.sv
paintPad.sv
tbPaintPad.sv

// ==== tbPaintPad.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbPaintPad
    import vgaPkg::*, mousePkg::*;
();

    localparam int     clkPeriod   = 100;
    localparam int     testCount   = 10; // reset picture plus nine packet bursts
    localparam int     packetCount = 17;
    localparam longint frameNs     = 64'(hPeriod) * 64'(vPeriod) * clkPeriod;
    localparam longint packetNs    = 3 * (ps2FrameBits * 100 + 200) * clkPeriod;
    localparam longint watchdogNs  = testCount * 4 * frameNs + packetCount * packetNs;

    logic       clkVga;
    logic       iRstN;
    logic       ps2Clk;
    logic       ps2Data;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hs;
    logic       vs;

    // reference model
    logic [10:0] hModel;
    logic [10:0] vModel;
    logic [11:0] expColor;
    logic        expHs;
    logic        expVs;
    int          curX;
    int          curY;
    bit          modelLeft;
    bit          modelRight;
    bit          cellPainted [32][32];
    bit [6:0]    seenColors;
    bit          hitZero;
    bit          hitMax;

    paintPad dut_i (
        .clkVga, .iRstN, .ps2Clk, .ps2Data, .red, .green, .blue, .hs, .vs
    );

    initial begin
        clkVga = 1'b0;
        forever #(clkPeriod / 2) clkVga = ~clkVga;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    function automatic int limitToField(input int value);
        if (value < 0) begin
            return 0;
        end else if (value > maxPos) begin
            return maxPos;
        end
        return value;
    endfunction

    function automatic logic [11:0] modelColor(input int h, input int v);
        int x;
        int y;
        x = h - int'(hSync + hBack); // field origin is the active corner
        y = v - int'(vSync + vBack);
        if (x < 0 || x >= int'(hActive) || y < 0 || y >= int'(vActive)) begin
            return colorBlank;
        end
        if (x >= curX && x < curX + int'(cursorSize) &&
            y >= curY && y < curY + int'(cursorSize)) begin
            if (modelLeft && !modelRight) begin
                return colorCursorPaint;
            end else if (modelRight && !modelLeft) begin
                return colorCursorErase;
            end
            return colorCursorIdle;
        end
        if (x < int'(fieldSize) && y < int'(fieldSize)) begin
            return cellPainted[x >> cellShift][y >> cellShift] ? colorPainted : colorEmpty;
        end
        return colorBackdrop;
    endfunction

    // expected outputs trail the counters by one clock
    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            hModel   <= '0;
            vModel   <= '0;
            expColor <= '0;
            expHs    <= 1'b0;
            expVs    <= 1'b0;
        end else begin
            expColor <= modelColor(hModel, vModel);
            expHs    <= (hModel >= hSync); // low during the first hSync clocks
            expVs    <= (vModel >= vSync);
            if (hModel == hPeriod - 1) begin
                hModel <= '0;
                vModel <= (vModel == vPeriod - 1) ? 11'd0 : vModel + 1'b1;
            end else begin
                hModel <= hModel + 1'b1;
            end
        end
    end

    always @(posedge clkVga) begin
        case (expColor)
            colorBlank:       seenColors[0] <= 1'b1;
            colorBackdrop:    seenColors[1] <= 1'b1;
            colorEmpty:       seenColors[2] <= 1'b1;
            colorPainted:     seenColors[3] <= 1'b1;
            colorCursorIdle:  seenColors[4] <= 1'b1;
            colorCursorPaint: seenColors[5] <= 1'b1;
            colorCursorErase: seenColors[6] <= 1'b1;
            default: ;
        endcase
    end

    assert property (@(posedge clkVga) disable iff (!iRstN) {red, green, blue} == expColor)
        else stopWithFailure($sformatf("** Error: red/green/blue expected %h, got %h",
            $sampled(expColor), $sampled({red, green, blue})));

    assert property (@(posedge clkVga) disable iff (!iRstN) hs == expHs)
        else stopWithFailure($sformatf("** Error: hs expected %h, got %h",
            $sampled(expHs), $sampled(hs)));

    assert property (@(posedge clkVga) disable iff (!iRstN) vs == expVs)
        else stopWithFailure($sformatf("** Error: vs expected %h, got %h",
            $sampled(expVs), $sampled(vs)));

    task automatic stepClocks(input int n);
        repeat (n) @(posedge clkVga);
        #10;
    endtask

    // start, 8 data bits lsb first, odd parity, stop; ps2Clk period of 100 clocks
    task automatic sendByte(input logic [7:0] value, input bit badParity);
        logic [10:0] frameBits;
        frameBits = {1'b1, (~^value) ^ badParity, value, 1'b0};
        for (int i = 0; i < ps2FrameBits; i++) begin
            ps2Data = frameBits[i];
            stepClocks(25);
            ps2Clk = 1'b0;
            stepClocks(50);
            ps2Clk = 1'b1;
            stepClocks(25);
        end
        stepClocks(200); // idle gap
    endtask

    task automatic applyPacket(input int dxVal, input int dyVal, input bit left, input bit right);
        int rawX;
        int rawY;
        rawX = curX + dxVal;
        rawY = curY - dyVal; // screen y grows downward
        hitZero    |= (rawX < 0) || (rawY < 0);
        hitMax     |= (rawX > maxPos) || (rawY > maxPos);
        curX       = limitToField(rawX);
        curY       = limitToField(rawY);
        modelLeft  = left;
        modelRight = right;
        if (left ^ right) begin
            cellPainted[curX >> cellShift][curY >> cellShift] = left;
        end
    endtask

    task automatic sendPacket(input int dxVal, input int dyVal, input bit left,
                              input bit right, input bit badMiddle);
        logic [8:0] dx9;
        logic [8:0] dy9;
        logic [7:0] status;
        dx9    = dxVal[8:0];
        dy9    = dyVal[8:0];
        status = {2'b00, dy9[8], dx9[8], 1'b1, 1'b0, right, left};
        sendByte(status, 1'b0);
        sendByte(dx9[7:0], badMiddle);
        // after a dropped frame the y byte must not look like a status byte
        sendByte(badMiddle ? (dy9[7:0] & 8'hF7) : dy9[7:0], 1'b0);
        if (!badMiddle) begin
            applyPacket(dxVal, dyVal, left, right);
        end
    endtask

    function automatic int randomDelta();
        return int'($urandom % 512) - 256;
    endfunction

    // first clock of the last blank line, packets land before active video
    task automatic waitForBlanking();
        stepClocks(1);
        while (!(vModel == vPeriod - 1 && hModel == 0)) begin
            stepClocks(1);
        end
    endtask

    initial begin
        #(watchdogNs);
        stopWithFailure("watchdog expired before all tests finished");
    end

    initial begin
        void'($urandom(6));
        iRstN   = 1'b0;
        ps2Clk  = 1'b1;
        ps2Data = 1'b1;
        curX    = 0;
        curY    = 0;
        stepClocks(3);
        if ({red, green, blue} !== 12'h000 || hs !== 1'b0 || vs !== 1'b0) begin
            stopWithFailure($sformatf("** Error: outputs in reset expected 000 0 0, got %h %h %h",
                {red, green, blue}, hs, vs));
        end
        iRstN = 1'b1;
        waitForBlanking();                  // reset picture shown
        repeat (5) sendPacket(randomDelta(), randomDelta(), 1'b0, 1'b0, 1'b0);
        waitForBlanking();
        repeat (3) sendPacket(-256, 255, 1'b0, 1'b0, 1'b0);  // pinned at 0,0
        waitForBlanking();
        repeat (3) sendPacket(255, -256, 1'b0, 1'b0, 1'b0);  // pinned at 511,511
        waitForBlanking();
        sendPacket(-200, 200, 1'b1, 1'b0, 1'b0); // paint cell under 311,311
        waitForBlanking();
        sendPacket(60, 0, 1'b0, 1'b0, 1'b0);     // painted cell now visible
        waitForBlanking();
        sendPacket(-60, 0, 1'b0, 1'b1, 1'b0);    // erase it again
        waitForBlanking();
        sendPacket(60, 0, 1'b0, 1'b0, 1'b0);
        waitForBlanking();
        sendPacket(100, -100, 1'b1, 1'b0, 1'b1); // broken middle frame, no effect
        waitForBlanking();
        sendPacket(randomDelta(), randomDelta(), 1'b0, 1'b0, 1'b0);
        waitForBlanking();
        if (seenColors == '1 && hitZero && hitMax) begin
            $display("Everything OK");
            $finish;
        end else begin
            stopWithFailure("stimulus never reached every color or both field edges");
        end
    end

endmodule

`default_nettype wire

// ==== paintPad.sv ====
`timescale 1ns/10ps
`default_nettype none

module paintPad
    import mousePkg::*;
(
    input  wire        clkVga,
    input  wire        iRstN,
    input  wire        ps2Clk,
    input  wire        ps2Data,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic       hs,
    output logic       vs
);

    logic                 byteValid;
    logic [7:0]           byteData;
    logic                 frameError;
    logic                 packetValid;
    logic [deltaBits-1:0] dx;
    logic [deltaBits-1:0] dy;
    logic                 btnLeft;
    logic                 btnRight;
    logic [posBits-1:0]   cursorX;
    logic [posBits-1:0]   cursorY;
    logic                 writeReq;
    logic                 writeValue;
    logic                 hsRaw;
    logic                 vsRaw;
    logic                 active;
    logic [10:0]          hPos;
    logic [10:0]          vPos;
    logic                 readEn;
    logic [9:0]           readAddr;
    logic                 readBit;

    ps2Receiver ps2Rx (
        .clkVga, .iRstN, .ps2Clk, .ps2Data, .byteValid, .byteData, .frameError
    );

    mousePacket packetAsm (
        .clkVga, .iRstN, .byteValid, .byteData, .frameError,
        .packetValid, .dx, .dy, .btnLeft, .btnRight
    );

    cursorTracker tracker (
        .clkVga, .iRstN, .packetValid, .dx, .dy, .btnLeft, .btnRight,
        .cursorX, .cursorY, .writeReq, .writeValue
    );

    vgaTiming timing (
        .clkVga, .iRstN, .hsRaw, .vsRaw, .active, .hPos, .vPos
    );

    bitmapArbiter arbiter (
        .clkVga, .iRstN, .readEn, .readAddr, .writeReq, .writeValue,
        .cursorX, .cursorY, .readBit
    );

    pixelRenderer renderer (
        .clkVga, .iRstN, .hsRaw, .vsRaw, .active, .hPos, .vPos,
        .cursorX, .cursorY, .btnLeft, .btnRight, .readBit,
        .readEn, .readAddr, .red, .green, .blue, .hs, .vs
    );

endmodule

`default_nettype wire

// ==== pixelRenderer.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixelRenderer
    import vgaPkg::*;
    import mousePkg::*;
(
    input  wire                clkVga,
    input  wire                iRstN,
    input  wire                hsRaw,
    input  wire                vsRaw,
    input  wire                active,
    input  wire  [10:0]        hPos,
    input  wire  [10:0]        vPos,
    input  wire  [posBits-1:0] cursorX,
    input  wire  [posBits-1:0] cursorY,
    input  wire                btnLeft,
    input  wire                btnRight,
    input  wire                readBit,
    output logic               readEn,
    output logic [9:0]         readAddr,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue,
    output logic               hs,
    output logic               vs
);

    logic        inField;
    logic        inCursor;
    logic [10:0] cursorRight;
    logic [10:0] cursorBottom;
    logic [11:0] cursorColor;
    logic [11:0] pixelColor;

    assign inField  = (hPos < fieldSize) && (vPos < fieldSize);
    assign readEn   = active && inField;
    assign readAddr = {hPos[$clog2(fieldSize)-1:cellShift], vPos[$clog2(fieldSize)-1:cellShift]};

    // box may hang over the right and bottom edge of the field
    assign cursorRight  = {2'b00, cursorX} + 11'(cursorSize);
    assign cursorBottom = {2'b00, cursorY} + 11'(cursorSize);
    assign inCursor     = (hPos >= {2'b00, cursorX}) && (hPos < cursorRight) &&
                          (vPos >= {2'b00, cursorY}) && (vPos < cursorBottom);

    always_comb begin
        if (btnLeft && !btnRight) begin
            cursorColor = colorCursorPaint;
        end else if (btnRight && !btnLeft) begin
            cursorColor = colorCursorErase;
        end else begin
            cursorColor = colorCursorIdle;
        end
    end

    always_comb begin
        if (!active) begin
            pixelColor = colorBlank;
        end else if (inCursor) begin
            pixelColor = cursorColor;
        end else if (inField && readBit) begin
            pixelColor = colorPainted;
        end else if (inField) begin
            pixelColor = colorEmpty;
        end else begin
            pixelColor = colorBackdrop;
        end
    end

    // syncs delayed with the color so they stay aligned
    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            {red, green, blue} <= '0;
            hs                 <= 1'b0;
            vs                 <= 1'b0;
        end else begin
            {red, green, blue} <= pixelColor;
            hs                 <= hsRaw;
            vs                 <= vsRaw;
        end
    end

endmodule

`default_nettype wire

// ==== bitmapArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bitmapArbiter
    import vgaPkg::*;
    import mousePkg::*;
(
    input  wire                clkVga,
    input  wire                iRstN,
    input  wire                readEn,
    input  wire  [9:0]         readAddr,
    input  wire                writeReq,
    input  wire                writeValue,
    input  wire  [posBits-1:0] cursorX,
    input  wire  [posBits-1:0] cursorY,
    output logic               readBit
);

    logic [1023:0] bitmap;     // one bit per 16x16 cell, x major
    logic [9:0]    writeAddr;
    logic          writeGrant;

    assign writeAddr  = {cursorX[posBits-1:cellShift], cursorY[posBits-1:cellShift]};
    assign writeGrant = writeReq & ~readEn; // renderer always first
    assign readBit    = bitmap[readAddr];

    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            bitmap <= '0;
        end else if (writeGrant) begin
            bitmap[writeAddr] <= writeValue;
        end
    end

    // the target cell must hold still through any render read cycle
    assert property (@(posedge clkVga) disable iff (!iRstN)
        readEn |=> bitmap[$past(writeAddr)] == $past(bitmap[writeAddr]))
        else $error("bitmap written during a render read");

endmodule

`default_nettype wire

// ==== vgaTiming.sv ====
`timescale 1ns/10ps
`default_nettype none

module vgaTiming
    import vgaPkg::*;
(
    input  wire         clkVga,
    input  wire         iRstN,
    output logic        hsRaw,
    output logic        vsRaw,
    output logic        active,
    output logic [10:0] hPos,
    output logic [10:0] vPos
);

    logic [10:0] hCnt;
    logic [10:0] vCnt;
    logic        lineEnd;

    assign lineEnd = (hCnt == hPeriod - 1'b1);

    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (lineEnd) begin
            hCnt <= '0;
            if (vCnt == vPeriod - 1'b1) begin
                vCnt <= '0;
            end else begin
                vCnt <= vCnt + 1'b1; // next line
            end
        end else begin
            hCnt <= hCnt + 1'b1;
        end
    end

    assign hsRaw = (hCnt >= hSync); // sync pulses are low
    assign vsRaw = (vCnt >= vSync);

    assign active = (hCnt >= hSync + hBack) && (hCnt < hSync + hBack + hActive) &&
                    (vCnt >= vSync + vBack) && (vCnt < vSync + vBack + vActive);

    // wraps to large values before the active window
    assign hPos = hCnt - (hSync + hBack);
    assign vPos = vCnt - (vSync + vBack);

endmodule

`default_nettype wire

// ==== cursorTracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cursorTracker
    import mousePkg::*;
(
    input  wire                  clkVga,
    input  wire                  iRstN,
    input  wire                  packetValid,
    input  wire  [deltaBits-1:0] dx,
    input  wire  [deltaBits-1:0] dy,
    input  wire                  btnLeft,
    input  wire                  btnRight,
    output logic [posBits-1:0]   cursorX,
    output logic [posBits-1:0]   cursorY,
    output logic                 writeReq,
    output logic                 writeValue
);

    logic signed [posBits+1:0] sumX;
    logic signed [posBits+1:0] sumY;

    function automatic logic [posBits-1:0] clampPos(input logic signed [posBits+1:0] value);
        if (value < 0) begin
            return '0;
        end else if (value > maxPos) begin
            return posBits'(maxPos);
        end
        return value[posBits-1:0];
    endfunction

    assign sumX = $signed({2'b00, cursorX}) + $signed(dx);
    assign sumY = $signed({2'b00, cursorY}) - $signed(dy); // mouse y is up, screen y is down

    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            cursorX    <= '0;
            cursorY    <= '0;
            writeReq   <= 1'b0;
            writeValue <= 1'b0;
        end else if (packetValid) begin
            cursorX    <= clampPos(sumX);
            cursorY    <= clampPos(sumY);
            writeReq   <= btnLeft ^ btnRight; // both held is idle
            writeValue <= btnLeft;
        end
    end

    assert property (@(posedge clkVga) disable iff (!iRstN)
        (cursorX <= maxPos) && (cursorY <= maxPos))
        else $error("cursor outside the field");

endmodule

`default_nettype wire

// ==== mousePacket.sv ====
`timescale 1ns/10ps
`default_nettype none

module mousePacket
    import mousePkg::*;
(
    input  wire                  clkVga,
    input  wire                  iRstN,
    input  wire                  byteValid,
    input  wire  [7:0]           byteData,
    input  wire                  frameError,
    output logic                 packetValid,
    output logic [deltaBits-1:0] dx,
    output logic [deltaBits-1:0] dy,
    output logic                 btnLeft,
    output logic                 btnRight
);

    logic [1:0] byteIdx; // 0 status, 1 x, 2 y
    logic [7:0] status;
    logic [7:0] xByte;

    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            byteIdx     <= '0;
            packetValid <= 1'b0;
            btnLeft     <= 1'b0;
            btnRight    <= 1'b0;
        end else begin
            packetValid <= 1'b0;
            if (frameError) begin
                byteIdx <= '0; // lost a byte, start over
            end else if (byteValid) begin
                if (byteIdx == packetBytes - 1) begin
                    byteIdx     <= '0;
                    packetValid <= 1'b1;
                    btnLeft     <= status[0]; // buttons from the latched status
                    btnRight    <= status[1];
                end else if (byteIdx != 2'd0 || byteData[syncBit]) begin
                    byteIdx <= byteIdx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clkVga) begin
        if (byteValid) begin
            case (byteIdx)
                2'd0: status <= byteData;
                2'd1: xByte  <= byteData;
                default: begin
                    dx <= {status[4], xByte};    // x sign in status bit 4
                    dy <= {status[5], byteData}; // y sign in status bit 5
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ps2Receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2Receiver
    import mousePkg::*;
(
    input  wire        clkVga,
    input  wire        iRstN,
    input  wire        ps2Clk,
    input  wire        ps2Data,
    output logic       byteValid,
    output logic [7:0] byteData,
    output logic       frameError
);

    logic [2:0]              clkSync;  // two sync stages plus previous sample
    logic [1:0]              dataSync;
    logic [3:0]              bitCount;
    logic [ps2FrameBits-1:0] frame;
    logic                    fallEdge;
    logic                    frameFull;
    logic                    frameGood;

    assign fallEdge  = clkSync[2] & ~clkSync[1];
    assign frameFull = (bitCount == ps2FrameBits);
    // start low, stop high, odd parity over data and parity bit
    assign frameGood = ~frame[0] & frame[ps2FrameBits-1] & (^frame[9:1]);

    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            clkSync  <= '1; // bus idles high
            dataSync <= '1;
        end else begin
            clkSync  <= {clkSync[1:0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
        end
    end

    always_ff @(posedge clkVga or negedge iRstN) begin
        if (!iRstN) begin
            bitCount   <= '0;
            byteValid  <= 1'b0;
            frameError <= 1'b0;
        end else begin
            byteValid  <= frameFull & frameGood;
            frameError <= frameFull & ~frameGood;
            if (frameFull) begin
                bitCount <= '0;
            end else if (fallEdge) begin
                bitCount <= bitCount + 1'b1;
            end
        end
    end

    // shift right, so the start bit ends up in bit 0
    always_ff @(posedge clkVga) begin
        if (fallEdge) begin
            frame <= {dataSync[1], frame[ps2FrameBits-1:1]};
        end
        if (frameFull) begin
            byteData <= frame[8:1];
        end
    end

    assert property (@(posedge clkVga) disable iff (!iRstN) bitCount <= ps2FrameBits)
        else $error("ps2Receiver bit count overran the frame");

endmodule

`default_nettype wire

// ==== mousePkg.sv ====
`default_nettype none

package mousePkg;

    // start, 8 data bits lsb first, odd parity, stop
    localparam int unsigned ps2FrameBits = 11;

    // status, x, y
    localparam int unsigned packetBytes = 3;
    localparam int unsigned syncBit     = 3; // always set in the status byte

    localparam int unsigned posBits   = 9;
    localparam int unsigned deltaBits = 9; // sign from status plus 8 bit magnitude
    localparam int          maxPos    = 511;

endpackage

`default_nettype wire

// ==== vgaPkg.sv ====
`default_nettype none

package vgaPkg;

    // 800x600 timing, counts in pixel clocks and lines
    localparam logic [10:0] hSync   = 11'd128;
    localparam logic [10:0] hBack   = 11'd88;
    localparam logic [10:0] hActive = 11'd800;
    localparam logic [10:0] hFront  = 11'd40;
    localparam logic [10:0] hPeriod = hSync + hBack + hActive + hFront; // 1056

    localparam logic [10:0] vSync   = 11'd4;
    localparam logic [10:0] vBack   = 11'd23;
    localparam logic [10:0] vActive = 11'd600;
    localparam logic [10:0] vFront  = 11'd1;
    localparam logic [10:0] vPeriod = vSync + vBack + vActive + vFront; // 628

    localparam int unsigned fieldSize  = 512; // square drawing field
    localparam int unsigned cellShift  = 4;   // 16 pixel cells
    localparam int unsigned cursorSize = 16;

    // rgb nibbles
    localparam logic [11:0] colorBlank       = 12'h222;
    localparam logic [11:0] colorBackdrop    = 12'h33F;
    localparam logic [11:0] colorEmpty       = 12'hFFF;
    localparam logic [11:0] colorPainted     = 12'hF0F;
    localparam logic [11:0] colorCursorIdle  = 12'hF00;
    localparam logic [11:0] colorCursorPaint = 12'h0F0;
    localparam logic [11:0] colorCursorErase = 12'h00F;

endpackage

`default_nettype wire
